//--- logic/csr_addr_pkg.sv
package csr_addr_pkg;

    localparam int XLEN = 32;

    ////////////////////
    // Address map
    ////////////////////

    typedef enum logic [11:0] {
        mstatus    = 12'h300,
        misa       = 12'h301,
        mie        = 12'h304,
        mtvec      = 12'h305,
        mscratch   = 12'h340,
        mepc       = 12'h341,
        mcause     = 12'h342,
        mtval      = 12'h343,
        mip        = 12'h344,
        mcycle     = 12'hB00,
        minstret   = 12'hB02,
        mcycleh    = 12'hB80,
        minstreth  = 12'hB82,
        cycle      = 12'hC00,    // User read-only views
        instret    = 12'hC02,
        cycleh     = 12'hC80,
        instreth   = 12'hC82,
        mvendorid  = 12'hF11,    // ID and config, read as zero
        marchid    = 12'hF12,
        mimpid     = 12'hF13,
        mhartid    = 12'hF14,
        mconfigptr = 12'hF15
    } csr_addr_e;

    // Same encoding as funct3[1:0] of the Zicsr instructions
    typedef enum logic [1:0] {
        write = 2'b01,
        set   = 2'b10,
        clear = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic            read_en;
        logic            write_en;
        csr_op_e         op;
        logic [11:0]     addr;      // Raw address, may be unmapped
        logic [XLEN-1:0] data;
        logic            killed;
    } csr_req_t;

    typedef struct packed {
        logic            en;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;      // Final value, mask already applied
    } csr_wr_t;

endpackage

//--- logic/csr_trap_pkg.sv
package csr_trap_pkg;

    typedef enum logic [1:0] {
        user    = 2'b00,
        machine = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        instr_misaligned    = 5'd0,
        instr_access_fault  = 5'd1,
        illegal_instruction = 5'd2,
        breakpoint          = 5'd3,
        load_misaligned     = 5'd4,
        load_access_fault   = 5'd5,
        store_misaligned    = 5'd6,
        store_access_fault  = 5'd7,
        ecall_u             = 5'd8,
        ecall_m             = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        m_sw_int  = 5'd3,
        m_tim_int = 5'd7,
        m_ext_int = 5'd11
    } irq_code_e;

    typedef struct packed {
        logic        raise_exception;
        logic        mret;
        exc_code_e   exc_code;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic        compressed;    // 16-bit instruction
        logic        jump;
        logic [31:0] jump_target;
    } trap_req_t;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtval;
    } machine_csr_t;

    localparam logic [31:0] MSTATUS_MASK = 32'h007E_19AA;
    localparam logic [31:0] MIE_MASK     = 32'h0000_0888;   // MSIE, MTIE, MEIE
    localparam logic [31:0] MISA_VALUE   = 32'h4010_1100;   // RV32 with I, M and U

endpackage

//--- logic/csr_access.sv
module csr_access
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
#(
    parameter bit COMPRESSED = 1'b0
) (
    input  csr_req_t        csr_req_i,
    input  machine_csr_t    regs_i,
    input  logic [XLEN-1:0] mip_i,
    input  logic [63:0]     mcycle_i,
    input  logic [63:0]     minstret_i,
    output csr_wr_t         csr_wr_o,
    output logic [XLEN-1:0] rdata_o
);

    // Trap vector and return address alignment
    localparam logic [XLEN-1:0] ALIGN_MASK = COMPRESSED ? 32'hFFFF_FFFE : 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] MISA_C     = {29'b0, COMPRESSED, 2'b0};

    logic            access_ok;
    logic [XLEN-1:0] cur_val;
    logic [XLEN-1:0] wmask;

    assign access_ok = !csr_req_i.killed;

    ////////////////////
    // Current value and mask
    ////////////////////

    always_comb begin
        cur_val = '0;
        wmask   = '1;
        case (csr_addr_e'(csr_req_i.addr))
            mstatus:   begin cur_val = regs_i.mstatus;   wmask = MSTATUS_MASK; end
            misa:      begin cur_val = MISA_VALUE | MISA_C; wmask = '0; end
            mie:       begin cur_val = regs_i.mie;       wmask = MIE_MASK; end
            mtvec:     begin cur_val = regs_i.mtvec;     wmask = ALIGN_MASK; end
            mscratch:  cur_val = regs_i.mscratch;
            mepc:      begin cur_val = regs_i.mepc;      wmask = ALIGN_MASK; end
            mcause:    cur_val = regs_i.mcause;
            mtval:     cur_val = regs_i.mtval;
            mip:       begin cur_val = mip_i;            wmask = '0; end
            mcycle:    cur_val = mcycle_i[31:0];
            mcycleh:   cur_val = mcycle_i[63:32];
            minstret:  cur_val = minstret_i[31:0];
            minstreth: cur_val = minstret_i[63:32];
            cycle:     begin cur_val = mcycle_i[31:0];   wmask = '0; end
            cycleh:    begin cur_val = mcycle_i[63:32];  wmask = '0; end
            instret:   begin cur_val = minstret_i[31:0]; wmask = '0; end
            instreth:  begin cur_val = minstret_i[63:32]; wmask = '0; end
            default:   wmask = '0;   // ID regs and unmapped
        endcase
    end

    ////////////////////
    // Operation
    ////////////////////

    always_comb begin
        csr_wr_o.en   = csr_req_i.write_en && access_ok;
        csr_wr_o.addr = csr_req_i.addr;
        case (csr_req_i.op)
            write:   csr_wr_o.data = (cur_val & ~wmask) | (csr_req_i.data & wmask);
            set:     csr_wr_o.data = cur_val | (csr_req_i.data & wmask);
            clear:   csr_wr_o.data = cur_val & ~(csr_req_i.data & wmask);
            default: csr_wr_o.data = cur_val;
        endcase
    end

    assign rdata_o = (csr_req_i.read_en && access_ok) ? cur_val : '0;

    // Pipeline must never issue a write with an undefined op
    always_comb begin
        a_op_legal: assert final (!csr_req_i.write_en || csr_req_i.op inside {write, set, clear});
    end

endmodule

//--- logic/csr_machine_regs.sv
module csr_machine_regs
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
#(
    parameter bit COMPRESSED = 1'b0
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         sys_reset_i,
    input  csr_wr_t      csr_wr_i,
    input  trap_req_t    trap_i,
    input  logic         interrupt_ack_i,
    input  irq_code_e    irq_code_i,
    output machine_csr_t regs_o,
    output logic         mstatus_mie_o,
    output priv_e        privilege_o
);

    // mstatus field positions
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;

    machine_csr_t regs_q;
    priv_e        priv_q;
    logic [31:0]  resume_pc;
    logic [31:0]  trap_status;

    // Acked instruction retires first, so resume after it
    always_comb begin
        if (trap_i.jump) begin
            resume_pc = trap_i.jump_target;
        end else if (COMPRESSED && trap_i.compressed) begin
            resume_pc = trap_i.pc + 32'd2;
        end else begin
            resume_pc = trap_i.pc + 32'd4;
        end
    end

    // Stack privilege and MIE on any trap entry
    always_comb begin
        trap_status                = regs_q.mstatus;
        trap_status[MPP_LSB +: 2]  = priv_q;
        trap_status[MPIE_BIT]      = regs_q.mstatus[MIE_BIT];
        trap_status[MIE_BIT]       = 1'b0;
    end

    ////////////////////
    // Register updates
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            regs_q <= '0;
            priv_q <= machine;
        end else if (sys_reset_i) begin
            regs_q <= '0;
            priv_q <= machine;
        end else if (trap_i.mret) begin
            regs_q.mstatus[MIE_BIT] <= regs_q.mstatus[MPIE_BIT];
            // Only two modes exist, anything but machine returns to user
            priv_q <= (regs_q.mstatus[MPP_LSB +: 2] == machine) ? machine : user;
        end else if (trap_i.raise_exception) begin
            regs_q.mstatus <= trap_status;
            regs_q.mcause  <= {27'b0, trap_i.exc_code};
            regs_q.mepc    <= trap_i.pc;
            regs_q.mtval   <= (trap_i.exc_code == illegal_instruction)
                              ? trap_i.instruction
                              : trap_i.pc;
            priv_q         <= machine;
        end else if (interrupt_ack_i) begin
            regs_q.mstatus <= trap_status;
            regs_q.mcause  <= {1'b1, 26'b0, irq_code_i};   // Interrupt flag in bit 31
            regs_q.mepc    <= resume_pc;
            priv_q         <= machine;
        end else if (csr_wr_i.en) begin
            case (csr_addr_e'(csr_wr_i.addr))
                mstatus:  regs_q.mstatus  <= csr_wr_i.data;
                mie:      regs_q.mie      <= csr_wr_i.data;
                mtvec:    regs_q.mtvec    <= csr_wr_i.data;
                mscratch: regs_q.mscratch <= csr_wr_i.data;
                mepc:     regs_q.mepc     <= csr_wr_i.data;
                mcause:   regs_q.mcause   <= csr_wr_i.data;
                mtval:    regs_q.mtval    <= csr_wr_i.data;
                default:  ;                                 // Counters or read-only
            endcase
        end
    end

    assign regs_o        = regs_q;
    assign mstatus_mie_o = regs_q.mstatus[MIE_BIT];
    assign privilege_o   = priv_q;

    // Decode stage never raises both in one cycle
    a_mret_exc_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(trap_i.mret && trap_i.raise_exception));

endmodule

//--- logic/csr_counters.sv
module csr_counters
    import csr_addr_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        sys_reset_i,
    input  csr_wr_t     csr_wr_i,
    input  logic        killed_i,
    input  logic        hold_i,
    output logic [63:0] mcycle_o,
    output logic [63:0] minstret_o
);

    logic [63:0] mcycle_q, mcycle_d;
    logic [63:0] minstret_q, minstret_d;

    always_comb begin
        mcycle_d   = mcycle_q + 64'd1;
        minstret_d = (killed_i || hold_i) ? minstret_q : minstret_q + 64'd1;
        // A CSR write replaces the increment in its cycle
        if (csr_wr_i.en) begin
            case (csr_addr_e'(csr_wr_i.addr))
                mcycle:    mcycle_d   = {mcycle_q[63:32], csr_wr_i.data};
                mcycleh:   mcycle_d   = {csr_wr_i.data, mcycle_q[31:0]};
                minstret:  minstret_d = {minstret_q[63:32], csr_wr_i.data};
                minstreth: minstret_d = {csr_wr_i.data, minstret_q[31:0]};
                default:   ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else if (sys_reset_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= mcycle_d;
            minstret_q <= minstret_d;
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

//--- logic/csr_irq_ctrl.sv
module csr_irq_ctrl
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic [XLEN-1:0] irq_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic            mstatus_mie_i,
    input  logic            interrupt_ack_i,
    output logic [XLEN-1:0] mip_o,
    output logic            interrupt_pending_o,
    output irq_code_e       irq_code_o
);

    logic [XLEN-1:0] mip_q;
    logic [XLEN-1:0] active;
    logic            pending_q;
    irq_code_e       code_q;

    assign active = mie_i & mip_q;   // Enabled and asserted lines

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q     <= '0;
            pending_q <= 1'b0;
            code_q    <= m_sw_int;
        end else begin
            mip_q     <= irq_i;
            pending_q <= mstatus_mie_i && (active != '0) && !interrupt_ack_i;
            // External first, then software, then timer
            if (active[11]) begin
                code_q <= m_ext_int;
            end else if (active[3]) begin
                code_q <= m_sw_int;
            end else if (active[7]) begin
                code_q <= m_tim_int;
            end
        end
    end

    assign mip_o               = mip_q;
    assign interrupt_pending_o = pending_q;
    assign irq_code_o          = code_q;

    // Holds only while mie keeps to the three machine interrupt bits
    a_pending_code: assert property (@(posedge clk) disable iff (!reset_n)
        pending_q |-> ($past(active) & (32'd1 << code_q)) != '0);

endmodule

//--- logic/csr_bank_top.sv
module csr_bank_top
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
#(
    parameter bit COMPRESSED = 1'b0
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            sys_reset_i,
    input  csr_req_t        csr_req_i,
    input  trap_req_t       trap_i,
    input  logic            hold_i,           // No instruction retires
    input  logic [XLEN-1:0] irq_i,
    input  logic            interrupt_ack_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic            interrupt_pending_o,
    output priv_e           privilege_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mtvec_o
);

    csr_wr_t         csr_wr;
    machine_csr_t    regs;
    logic            mstatus_mie;
    logic [XLEN-1:0] mip;
    logic [63:0]     mcycle_val;
    logic [63:0]     minstret_val;
    irq_code_e       irq_code;

    csr_access #(
        .COMPRESSED (COMPRESSED)
    ) u_access (
        .csr_req_i  (csr_req_i),
        .regs_i     (regs),
        .mip_i      (mip),
        .mcycle_i   (mcycle_val),
        .minstret_i (minstret_val),
        .csr_wr_o   (csr_wr),
        .rdata_o    (csr_rdata_o)
    );

    csr_machine_regs #(
        .COMPRESSED (COMPRESSED)
    ) u_regs (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .csr_wr_i        (csr_wr),
        .trap_i          (trap_i),
        .interrupt_ack_i (interrupt_ack_i),
        .irq_code_i      (irq_code),
        .regs_o          (regs),
        .mstatus_mie_o   (mstatus_mie),
        .privilege_o     (privilege_o)
    );

    csr_counters u_counters (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset_i),
        .csr_wr_i    (csr_wr),
        .killed_i    (csr_req_i.killed),
        .hold_i      (hold_i),
        .mcycle_o    (mcycle_val),
        .minstret_o  (minstret_val)
    );

    csr_irq_ctrl u_irq (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .mie_i               (regs.mie),
        .mstatus_mie_i       (mstatus_mie),
        .interrupt_ack_i     (interrupt_ack_i),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

    assign mepc_o  = regs.mepc;
    assign mtvec_o = regs.mtvec;

endmodule

//--- verif/csr_bank_tb.sv
module csr_bank_tb
    import csr_addr_pkg::*;
    import csr_trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MAX_CYCLES   = 400;             // Tests need about 100
    localparam logic [31:0] LFSR_SEED    = 32'hbde3_4862;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] STATUS_WMASK = 32'h007E_19AA;
    localparam logic [31:0] IE_WMASK     = 32'h0000_0888;
    localparam logic [31:0] ALIGN4_WMASK = 32'hFFFF_FFFC;   // mtvec and mepc without C
    localparam logic [31:0] ST_MIE       = 32'h0000_0008;
    localparam logic [31:0] ST_MPIE      = 32'h0000_0080;
    localparam logic [31:0] ST_MPP       = 32'h0000_1800;

    logic        clk;
    logic        reset_n;
    logic        sys_reset;
    csr_req_t    csr_req;
    trap_req_t   trap;
    logic        hold;
    logic [31:0] irq;
    logic        ack;
    logic [31:0] csr_rdata;
    logic        pending;
    priv_e       privilege;
    logic [31:0] mepc_out;
    logic [31:0] mtvec_out;

    // Armed checks and their expected values
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    logic [31:0] rd_mask;
    logic        chk_priv;
    priv_e       exp_priv;
    logic        chk_pend;
    logic        exp_pend;
    logic        chk_mepc;
    logic [31:0] exp_mepc;
    logic        chk_mtvec;
    logic [31:0] exp_mtvec;

    // Model of the machine registers
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    priv_e       m_priv;

    logic [31:0] lfsr_state;
    int          cycle_count  = 0;
    int          err_count    = 0;
    int          errs_before  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    csr_bank_top #(
        .COMPRESSED (1'b0)
    ) u_dut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset),
        .csr_req_i           (csr_req),
        .trap_i              (trap),
        .hold_i              (hold),
        .irq_i               (irq),
        .interrupt_ack_i     (ack),
        .csr_rdata_o         (csr_rdata),
        .interrupt_pending_o (pending),
        .privilege_o         (privilege),
        .mepc_o              (mepc_out),
        .mtvec_o             (mtvec_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_rdata: assert property (@(posedge clk) disable iff (!reset_n)
        chk_rdata |-> ((csr_rdata & rd_mask) == exp_rdata))
    else begin
        err_count = err_count + 1;
        $display("** Error at %0t: csr_rdata_o expected %h, got %h", $time,
                 $sampled(exp_rdata), $sampled(csr_rdata) & $sampled(rd_mask));
    end

    a_priv: assert property (@(posedge clk) disable iff (!reset_n)
        chk_priv |-> (privilege == exp_priv))
    else begin
        err_count = err_count + 1;
        $display("** Error at %0t: privilege_o expected %0d, got %0d", $time,
                 $sampled(exp_priv), $sampled(privilege));
    end

    a_pending: assert property (@(posedge clk) disable iff (!reset_n)
        chk_pend |-> (pending == exp_pend))
    else begin
        err_count = err_count + 1;
        $display("** Error at %0t: interrupt_pending_o expected %b, got %b", $time,
                 $sampled(exp_pend), $sampled(pending));
    end

    a_mepc: assert property (@(posedge clk) disable iff (!reset_n)
        chk_mepc |-> (mepc_out == exp_mepc))
    else begin
        err_count = err_count + 1;
        $display("** Error at %0t: mepc_o expected %h, got %h", $time,
                 $sampled(exp_mepc), $sampled(mepc_out));
    end

    a_mtvec: assert property (@(posedge clk) disable iff (!reset_n)
        chk_mtvec |-> (mtvec_out == exp_mtvec))
    else begin
        err_count = err_count + 1;
        $display("** Error at %0t: mtvec_o expected %h, got %h", $time,
                 $sampled(exp_mtvec), $sampled(mtvec_out));
    end

    ////////////////////
    // Helpers
    ////////////////////

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] apply_csr_op(input csr_op_e op, input logic [31:0] cur,
                                                 input logic [31:0] d, input logic [31:0] mask);
        case (op)
            write:   return (cur & ~mask) | (d & mask);
            set:     return cur | (d & mask);
            clear:   return cur & ~(d & mask);
            default: return cur;
        endcase
    endfunction

    // mstatus after any trap entry
    function automatic logic [31:0] stacked_status(input logic [31:0] status, input priv_e priv);
        logic [31:0] result;
        result = (status & ~(ST_MPP | ST_MPIE | ST_MIE)) | {19'b0, priv, 11'b0};
        if ((status & ST_MIE) != 0) begin
            result = result | ST_MPIE;
        end
        return result;
    endfunction

    task automatic drive_idle();
        csr_req   <= '0;
        trap      <= '0;
        hold      <= 1'b0;
        ack       <= 1'b0;
        chk_rdata <= 1'b0;
        chk_priv  <= 1'b0;
        chk_pend  <= 1'b0;
        chk_mepc  <= 1'b0;
        chk_mtvec <= 1'b0;
        rd_mask   <= '1;
    endtask

    task automatic idle_cycle(input logic hold_en, input logic kill_en);
        @(posedge clk);
        drive_idle();
        hold           <= hold_en;
        csr_req.killed <= kill_en;
    endtask

    task automatic drive_access(input logic rd, input logic wr, input csr_op_e op,
                                input logic [11:0] addr, input logic [31:0] data,
                                input logic kill);
        @(posedge clk);
        drive_idle();
        csr_req <= '{read_en: rd, write_en: wr, op: op, addr: addr, data: data, killed: kill};
    endtask

    task automatic write_csr(input csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] data, input logic kill);
        drive_access(1'b0, 1'b1, op, addr, data, kill);
    endtask

    // Result is compared on the following edge
    task automatic check_read(input logic rd, input logic kill, input logic [11:0] addr,
                              input logic [31:0] mask, input logic [31:0] expected);
        drive_access(rd, 1'b0, write, addr, '0, kill);
        chk_rdata <= 1'b1;
        rd_mask   <= mask;
        exp_rdata <= expected & mask;
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] expected);
        check_read(1'b1, 1'b0, addr, '1, expected);
    endtask

    task automatic enter_exception(input exc_code_e code, input logic [31:0] pc,
                                   input logic [31:0] instr);
        @(posedge clk);
        drive_idle();
        trap.raise_exception <= 1'b1;
        trap.exc_code        <= code;
        trap.pc              <= pc;
        trap.instruction     <= instr;
        m_mstatus = stacked_status(m_mstatus, m_priv);
        m_priv    = machine;
    endtask

    task automatic issue_mret();
        @(posedge clk);
        drive_idle();
        trap.mret <= 1'b1;
        m_mstatus = (m_mstatus & ST_MPIE) != 0 ? (m_mstatus | ST_MIE) : (m_mstatus & ~ST_MIE);
        m_priv    = priv_e'(m_mstatus[12:11]);
    endtask

    task automatic ack_interrupt(input logic [31:0] pc, input logic jump,
                                 input logic [31:0] target);
        @(posedge clk);
        drive_idle();
        ack              <= 1'b1;
        trap.pc          <= pc;
        trap.jump        <= jump;
        trap.jump_target <= target;
        m_mstatus = stacked_status(m_mstatus, m_priv);
        m_priv    = machine;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        drive_idle();
        @(posedge clk);   // Last armed check has fired by now
        tests_run++;
        if (err_count == errs_before) begin
            $display("Test %0d (%s): ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): %0d errors", tests_run, name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic masked_ops_test();
        logic [31:0] data;
        logic [31:0] pick;
        csr_op_e     op;
        for (int round = 0; round < 4; round++) begin
            for (int r = 0; r < 3; r++) begin
                pick = rand_bits(2);
                op   = (round == 0 || pick == 0) ? write : (pick == 1 ? set : clear);
                data = rand_bits(32);
                case (r)
                    0: begin
                        m_mscratch = apply_csr_op(op, m_mscratch, data, '1);
                        write_csr(op, mscratch, data, 1'b0);
                        read_expect(mscratch, m_mscratch);
                    end
                    1: begin
                        m_mie = apply_csr_op(op, m_mie, data, IE_WMASK);
                        write_csr(op, mie, data, 1'b0);
                        read_expect(mie, m_mie);
                    end
                    default: begin
                        m_mtvec = apply_csr_op(op, m_mtvec, data, ALIGN4_WMASK);
                        write_csr(op, mtvec, data, 1'b0);
                        read_expect(mtvec, m_mtvec);
                        chk_mtvec <= 1'b1;
                        exp_mtvec <= m_mtvec;
                    end
                endcase
            end
        end
        finish_test("masked operations");
    endtask

    task automatic blocked_access_test();
        m_mscratch = 32'h5A5A_C3C3;
        write_csr(write, mscratch, m_mscratch, 1'b0);
        write_csr(write, mscratch, rand_bits(32), 1'b1);   // Killed
        read_expect(mscratch, m_mscratch);
        check_read(1'b0, 1'b0, mscratch, '1, '0);          // read_en low
        check_read(1'b1, 1'b1, mscratch, '1, '0);
        read_expect(12'h7C0, '0);                          // Unmapped
        read_expect(mvendorid, '0);
        finish_test("blocked accesses");
    endtask

    task automatic exception_test();
        logic [31:0] pc;
        logic [31:0] instr;
        // Return to user mode with MIE set
        m_mstatus = apply_csr_op(write, m_mstatus, ST_MPIE, STATUS_WMASK);
        write_csr(write, mstatus, ST_MPIE, 1'b0);
        issue_mret();
        pc    = rand_bits(30) << 2;
        instr = rand_bits(32);
        enter_exception(illegal_instruction, pc, instr);
        read_expect(mcause, 32'(illegal_instruction));
        chk_priv <= 1'b1;
        exp_priv <= machine;
        chk_mepc <= 1'b1;
        exp_mepc <= pc;
        read_expect(mepc, pc);
        read_expect(mtval, instr);
        check_read(1'b1, 1'b0, mstatus, ST_MPIE | ST_MIE, m_mstatus);
        // Not illegal, so mtval takes pc
        pc = rand_bits(30) << 2;
        enter_exception(load_access_fault, pc, rand_bits(32));
        read_expect(mcause, 32'(load_access_fault));
        read_expect(mtval, pc);
        check_read(1'b1, 1'b0, mstatus, ST_MPIE | ST_MIE, m_mstatus);
        finish_test("exception entry");
    endtask

    task automatic mret_test();
        m_mstatus = apply_csr_op(write, m_mstatus, ST_MPIE, STATUS_WMASK);   // MPP user
        write_csr(write, mstatus, ST_MPIE, 1'b0);
        issue_mret();
        check_read(1'b1, 1'b0, mstatus, ST_MIE, m_mstatus);
        chk_priv <= 1'b1;
        exp_priv <= m_priv;
        m_mstatus = apply_csr_op(write, m_mstatus, ST_MPP, STATUS_WMASK);    // MPP machine
        write_csr(write, mstatus, ST_MPP, 1'b0);
        issue_mret();
        check_read(1'b1, 1'b0, mstatus, ST_MIE, m_mstatus);
        chk_priv <= 1'b1;
        exp_priv <= m_priv;
        finish_test("mret");
    endtask

    task automatic interrupt_test();
        logic [31:0] pc;
        logic [31:0] target;
        m_mie = apply_csr_op(write, m_mie, IE_WMASK, IE_WMASK);
        write_csr(write, mie, IE_WMASK, 1'b0);
        m_mstatus = apply_csr_op(write, m_mstatus, ST_MIE, STATUS_WMASK);
        write_csr(write, mstatus, ST_MIE, 1'b0);
        idle_cycle(1'b0, 1'b0);
        irq <= 32'h0000_0080;            // Timer line
        idle_cycle(1'b0, 1'b0);
        chk_pend <= 1'b1;                // Still low after one edge
        exp_pend <= 1'b0;
        idle_cycle(1'b0, 1'b0);
        chk_pend <= 1'b1;
        exp_pend <= 1'b1;
        idle_cycle(1'b0, 1'b0);
        irq <= 32'h0000_0888;            // Software, timer and external together
        idle_cycle(1'b0, 1'b0);
        idle_cycle(1'b0, 1'b0);
        chk_pend <= 1'b1;
        exp_pend <= 1'b1;
        pc = rand_bits(30) << 2;
        ack_interrupt(pc, 1'b0, '0);
        read_expect(mcause, 32'h8000_0000 | 32'd11);
        chk_pend <= 1'b1;
        exp_pend <= 1'b0;
        read_expect(mepc, pc + 32'd4);
        // Jump case needs MIE back on
        m_mstatus = apply_csr_op(write, m_mstatus, ST_MIE, STATUS_WMASK);
        write_csr(write, mstatus, ST_MIE, 1'b0);
        target = rand_bits(30) << 2;
        ack_interrupt(rand_bits(30) << 2, 1'b1, target);
        read_expect(mepc, target);
        chk_pend <= 1'b1;
        exp_pend <= 1'b0;
        chk_mepc <= 1'b1;
        exp_mepc <= target;
        read_expect(mcause, 32'h8000_0000 | 32'd11);
        irq <= '0;
        finish_test("interrupts");
    endtask

    task automatic counter_test();
        logic [31:0] base;
        base = rand_bits(28);
        write_csr(write, mcycle, base, 1'b0);
        read_expect(mcycle, base);
        repeat (4) idle_cycle(1'b0, 1'b0);
        read_expect(mcycle, base + 32'd5);   // Five edges after the first read
        base = rand_bits(28);
        write_csr(write, minstret, base, 1'b0);
        read_expect(minstret, base);         // This cycle retires
        idle_cycle(1'b1, 1'b0);              // Held
        idle_cycle(1'b0, 1'b1);              // Killed
        read_expect(minstret, base + 32'd1);
        idle_cycle(1'b0, 1'b0);
        read_expect(minstret, base + 32'd3);
        finish_test("counters");
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        sys_reset  = 1'b0;
        csr_req    = '0;
        trap       = '0;
        hold       = 1'b0;
        irq        = '0;
        ack        = 1'b0;
        chk_rdata  = 1'b0;
        exp_rdata  = '0;
        rd_mask    = '1;
        chk_priv   = 1'b0;
        exp_priv   = machine;
        chk_pend   = 1'b0;
        exp_pend   = 1'b0;
        chk_mepc   = 1'b0;
        exp_mepc   = '0;
        chk_mtvec  = 1'b0;
        exp_mtvec  = '0;
        m_mstatus  = '0;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_priv     = machine;
        lfsr_state = LFSR_SEED;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        masked_ops_test();
        blocked_access_test();
        exception_test();
        mret_test();
        interrupt_test();
        counter_test();
        $display("Summary: %0d tests run, %0d with errors, %0d check errors in total",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/csr_addr_pkg.sv
logic/csr_trap_pkg.sv
logic/csr_access.sv
logic/csr_machine_regs.sv
logic/csr_counters.sv
logic/csr_irq_ctrl.sv
logic/csr_bank_top.sv
verif/csr_bank_tb.sv

//--- Bender.yml
package:
  name: csr_bank

sources:
  - logic/csr_addr_pkg.sv
  - logic/csr_trap_pkg.sv
  - logic/csr_access.sv
  - logic/csr_machine_regs.sv
  - logic/csr_counters.sv
  - logic/csr_irq_ctrl.sv
  - logic/csr_bank_top.sv
  - target: test
    files:
      - verif/csr_bank_tb.sv
